/* design/branch_predictor.sv */
/*
 * Branch predictor
 * A table of 2-bit saturating direction counters and a tagged branch
 * target buffer, both indexed by halfword PC bits. Looked up with the
 * current PC, trained by resolutions from the back end, and flags a
 * misprediction when a speculative resolution disagrees with its counter
 */

`timescale 1ns/10ps

module branch_predictor #(
    parameter int PREDICTOR_SIZE = 32,
    parameter int BTB_SIZE       = 32
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  fetch_pkg::data_word_t pc_i,
    input  fetch_pkg::resolve_t   resolve_i,
    output fetch_pkg::predict_t   predict_o,
    output logic                 mispredicted_o
);

    localparam int PRED_BITS = $clog2(PREDICTOR_SIZE);
    localparam int BTB_BITS  = $clog2(BTB_SIZE);

    // Tag keeps every PC bit above the buffer index, bit 0 is always zero
    localparam int TAG_BITS  = fetch_pkg::XLEN - BTB_BITS - 1;

    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        fetch_pkg::data_word_t target;
    } btb_entry_t;

    logic [1:0]          counter_q [PREDICTOR_SIZE];
    logic [BTB_SIZE-1:0] btb_valid_q;
    btb_entry_t          btb_q [BTB_SIZE];

    // ==================
    // Lookup
    // ==================

    logic [PRED_BITS-1:0] lookup_pred_idx;
    logic [BTB_BITS-1:0]  lookup_btb_idx;
    logic [TAG_BITS-1:0]  lookup_tag;
    btb_entry_t           lookup_entry;

    assign lookup_pred_idx = pc_i[PRED_BITS:1];
    assign lookup_btb_idx  = pc_i[BTB_BITS:1];
    assign lookup_tag      = pc_i[fetch_pkg::XLEN-1:BTB_BITS+1];
    assign lookup_entry    = btb_q[lookup_btb_idx];

    always_comb begin
        // A hit needs a valid entry whose stored tag matches this PC
        predict_o.hit    = btb_valid_q[lookup_btb_idx] & (lookup_entry.tag == lookup_tag);
        // Upper counter bit is the predicted direction
        predict_o.taken  = counter_q[lookup_pred_idx][1];
        predict_o.target = lookup_entry.target;
    end

    // ==================
    // Training
    // ==================

    logic [PRED_BITS-1:0] train_pred_idx;
    logic [BTB_BITS-1:0]  train_btb_idx;
    logic [TAG_BITS-1:0]  train_tag;
    logic [1:0]           train_counter;
    logic [1:0]           next_counter;
    logic                 train_en;
    logic                 outcome;

    assign train_pred_idx = resolve_i.instr_addr[PRED_BITS:1];
    assign train_btb_idx  = resolve_i.instr_addr[BTB_BITS:1];
    assign train_tag      = resolve_i.instr_addr[fetch_pkg::XLEN-1:BTB_BITS+1];
    assign train_counter  = counter_q[train_pred_idx];

    // Only real control transfers train, a jump always counts as taken
    assign train_en = resolve_i.executed & (resolve_i.branch | resolve_i.jump);
    assign outcome  = resolve_i.taken | resolve_i.jump;

    // One saturating step toward the resolved direction
    always_comb begin
        next_counter = train_counter;
        if (outcome && (train_counter != 2'b11)) begin
            next_counter = train_counter + 2'd1;
        end else if (!outcome && (train_counter != 2'b00)) begin
            next_counter = train_counter - 2'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // Every counter starts weakly not taken
            for (int i = 0; i < PREDICTOR_SIZE; i++) begin
                counter_q[i] <= 2'b01;
            end
        end else if (train_en) begin
            counter_q[train_pred_idx] <= next_counter;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            btb_valid_q <= '0;
        end else if (train_en && outcome) begin
            btb_valid_q[train_btb_idx] <= 1'b1;
        end
    end

    // Taken transfers record where they went
    always_ff @(posedge clk_i) begin
        if (train_en && outcome) begin
            btb_q[train_btb_idx] <= '{tag: train_tag, target: resolve_i.next_addr};
        end
    end

    // Compared against the counter as it stood before this update
    assign mispredicted_o = resolve_i.executed & resolve_i.speculative
                          & (outcome != train_counter[1]);

    // The back end never reports one instruction as both branch and jump
    branch_jump_exclusive_a : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        resolve_i.executed |-> !(resolve_i.branch && resolve_i.jump)
    );

endmodule : branch_predictor

/* design/fetch_pkg.sv */
/*
 * Front end shared definitions
 * Word width, PC reset value and the packed structs that carry trap
 * requests, branch resolutions, predictor results and fetch packets
 * between the front end units and the testbench
 */

package fetch_pkg;

    // Width of an address or instruction word
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] data_word_t;

    // The PC register starts one word before zero
    // The first sequential step then fetches from address 0
    localparam data_word_t PC_RESET_VALUE = -32'sd4;

    // Trap request from the back end, handler_pc is taken on either flag
    typedef struct packed {
        logic       exception;
        logic       interrupt;
        data_word_t handler_pc;
    } trap_t;

    // Branch or jump resolution, valid for one cycle while executed is high
    // next_addr is the target when taken or a jump, else the fall-through
    typedef struct packed {
        logic       executed;
        logic       branch;
        logic       jump;
        logic       taken;
        logic       speculative;
        data_word_t instr_addr;
        data_word_t next_addr;
    } resolve_t;

    // Predictor answer for the PC currently being fetched
    typedef struct packed {
        logic       hit;
        logic       taken;
        data_word_t target;
    } predict_t;

    // Registered output of the fetch stage
    typedef struct packed {
        logic       valid;
        logic       compressed;
        logic       speculative;
        logic       mispredicted;
        data_word_t pc;
        data_word_t instr;
    } fetch_pkt_t;

endpackage : fetch_pkg

/* design/fetch_stage.sv */
/*
 * Instruction fetch stage
 * Detects compressed instructions and registers the returned word
 * together with its PC and speculation flags as one fetch packet
 */

`timescale 1ns/10ps

module fetch_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic                  branch_flush_i,
    input  logic                  fetch_valid_i,
    input  fetch_pkg::data_word_t fetch_instr_i,
    input  fetch_pkg::data_word_t pc_i,
    input  logic                  speculative_i,
    input  logic                  mispredicted_i,
    output logic                  compressed_o,
    output fetch_pkg::fetch_pkt_t packet_o
);

    logic                  compressed;
    fetch_pkg::fetch_pkt_t pkt_q;

    // Full length encodings have both low bits set
    assign compressed = (fetch_instr_i[1:0] != 2'b11);

    // The PC step only cares about instructions that really arrived
    assign compressed_o = compressed & fetch_valid_i;

    // ==================
    // Packet register
    // ==================

    always_ff @(posedge clk_i) begin
        // Only the valid bit sees reset and the branch flush
        if (!rst_n_i) begin
            pkt_q.valid <= 1'b0;
        end else if (branch_flush_i) begin
            pkt_q.valid <= 1'b0;
        end else if (!stall_i) begin
            pkt_q.valid <= fetch_valid_i;
        end
        // Payload follows the same stall but is only meaningful with valid
        if (!stall_i) begin
            pkt_q.compressed   <= compressed;
            pkt_q.speculative  <= speculative_i;
            pkt_q.mispredicted <= mispredicted_i;
            pkt_q.pc           <= pc_i;
            pkt_q.instr        <= fetch_instr_i;
        end
    end

    assign packet_o = pkt_q;

endmodule : fetch_stage

/* design/front_end.sv */
/*
 * Front end top level
 * Connects the PC generator, the branch predictor and the fetch stage,
 * and keeps the register that marks a fetch as predicted by the buffer
 */

`timescale 1ns/10ps

module front_end #(
    parameter int PREDICTOR_SIZE = 32,
    parameter int BTB_SIZE       = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  logic                  branch_flush_i,
    input  fetch_pkg::trap_t      trap_i,
    input  fetch_pkg::resolve_t   resolve_i,
    input  logic                  fetch_valid_i,
    input  fetch_pkg::data_word_t fetch_instr_i,
    output logic                  fetch_o,
    output fetch_pkg::data_word_t fetch_addr_o,
    output logic                  fetch_ack_o,
    output fetch_pkg::fetch_pkt_t packet_o
);

    fetch_pkg::data_word_t pc;
    fetch_pkg::predict_t   predict;
    logic                  mispredicted;
    logic                  compressed;
    logic                  pcgen_speculative;

    // ==================
    // PC generation
    // ==================

    branch_predictor #(
        .PREDICTOR_SIZE ( PREDICTOR_SIZE ),
        .BTB_SIZE       ( BTB_SIZE       )
    ) predictor_unit (
        .clk_i          ( clk_i        ),
        .rst_n_i        ( rst_n_i      ),
        .pc_i           ( pc           ),
        .resolve_i      ( resolve_i    ),
        .predict_o      ( predict      ),
        .mispredicted_o ( mispredicted )
    );

    pc_generator pcgen_unit (
        .clk_i          ( clk_i        ),
        .rst_n_i        ( rst_n_i      ),
        .stall_i        ( stall_i      ),
        .trap_i         ( trap_i       ),
        .resolve_i      ( resolve_i    ),
        .predict_i      ( predict      ),
        .mispredicted_i ( mispredicted ),
        .compressed_i   ( compressed   ),
        .fetch_o        ( fetch_o      ),
        .fetch_addr_o   ( fetch_addr_o ),
        .pc_o           ( pc           )
    );

    // Marks the instruction fetched after a buffer hit as speculative
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pcgen_speculative <= 1'b0;
        end else if (flush_i) begin
            pcgen_speculative <= 1'b0;
        end else if (!stall_i) begin
            pcgen_speculative <= predict.hit;
        end
    end

    // ==================
    // Instruction fetch
    // ==================

    fetch_stage fetch_unit (
        .clk_i          ( clk_i             ),
        .rst_n_i        ( rst_n_i           ),
        .stall_i        ( stall_i           ),
        .branch_flush_i ( branch_flush_i    ),
        .fetch_valid_i  ( fetch_valid_i     ),
        .fetch_instr_i  ( fetch_instr_i     ),
        .pc_i           ( pc                ),
        .speculative_i  ( pcgen_speculative ),
        .mispredicted_i ( mispredicted      ),
        .compressed_o   ( compressed        ),
        .packet_o       ( packet_o          )
    );

    assign fetch_ack_o = packet_o.valid;

endmodule : front_end

/* design/pc_generator.sv */
/*
 * PC generator
 * Holds the program counter and chooses the next fetch address by
 * priority: trap, resolved branch, predicted branch, sequential step
 */

`timescale 1ns/10ps

module pc_generator (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  fetch_pkg::trap_t      trap_i,
    input  fetch_pkg::resolve_t   resolve_i,
    input  fetch_pkg::predict_t   predict_i,
    input  logic                  mispredicted_i,
    input  logic                  compressed_i,
    output logic                  fetch_o,
    output fetch_pkg::data_word_t fetch_addr_o,
    output fetch_pkg::data_word_t pc_o
);

    fetch_pkg::data_word_t pc_q;
    fetch_pkg::data_word_t seq_addr;
    logic                  trap_req;
    logic                  resolve_redirect;

    // Valid compressed instructions are one halfword long
    assign seq_addr = compressed_i ? (pc_q + 32'd2) : (pc_q + 32'd4);

    assign trap_req = trap_i.exception | trap_i.interrupt;

    // A non speculative transfer always redirects when taken
    // A speculative one only redirects when the predictor got it wrong
    always_comb begin
        if (resolve_i.speculative) begin
            resolve_redirect = mispredicted_i;
        end else begin
            resolve_redirect = resolve_i.taken | resolve_i.jump;
        end
    end

    // ==================
    // Next address
    // ==================

    always_comb begin
        fetch_addr_o = pc_q;

        if (trap_req) begin
            fetch_addr_o = trap_i.handler_pc;
        end else if (resolve_i.executed && resolve_redirect) begin
            fetch_addr_o = resolve_i.next_addr;
        end else if (!stall_i) begin
            if (predict_i.hit && predict_i.taken) begin
                fetch_addr_o = predict_i.target;
            end else begin
                fetch_addr_o = seq_addr;
            end
        end
    end

    // Redirects still fetch while the pipeline is stalled
    assign fetch_o = trap_req | resolve_i.executed | !stall_i;

    // Holding is done by feeding the PC back through the mux
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= fetch_pkg::PC_RESET_VALUE;
        end else begin
            pc_q <= fetch_addr_o;
        end
    end

    assign pc_o = pc_q;

    fetch_addr_halfword_a : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        fetch_addr_o[0] == 1'b0
    );

endmodule : pc_generator

/* files.f */
design/fetch_pkg.sv
design/branch_predictor.sv
design/pc_generator.sv
design/fetch_stage.sv
design/front_end.sv
test/fe_checker.sv
test/tb_front_end.sv

/* run.sh */
#!/bin/sh
# Build and run the front end testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module tb_front_end \
    -f files.f -o tb_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

/* test/fe_checker.sv */
/*
 * Front end checker
 * Samples the DUT ports on every rising edge, compares them with the
 * reference model's expected values and reports per test and in total
 */

`timescale 1ns/10ps

module fe_checker (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  fetch_i,
    input  fetch_pkg::data_word_t fetch_addr_i,
    input  logic                  fetch_ack_i,
    input  fetch_pkg::fetch_pkt_t packet_i,
    input  logic                  exp_fetch_i,
    input  fetch_pkg::data_word_t exp_addr_i,
    input  fetch_pkg::fetch_pkt_t exp_pkt_i,
    input  int                    test_num_i,
    input  logic                  test_last_i,
    input  logic                  all_done_i,
    output int                    error_count_o
);

    int test_errors;
    int test_checks;
    int total_checks;
    int tests_done;

    initial begin
        error_count_o = 0;
        test_errors   = 0;
        test_checks   = 0;
        total_checks  = 0;
        tests_done    = 0;
    end

    task automatic report_error(input string what, input logic [31:0] got,
                                input logic [31:0] want);
        $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
        test_errors++;
        error_count_o++;
    endtask

    // ====================
    // Comparison
    // ====================

    // Payload fields only matter while the packet is valid
    task automatic compare_outputs();
        test_checks++;
        total_checks++;
        if (fetch_i !== exp_fetch_i) begin
            report_error("fetch_o", 32'(fetch_i), 32'(exp_fetch_i));
        end
        if (fetch_addr_i !== exp_addr_i) begin
            report_error("fetch_addr_o", fetch_addr_i, exp_addr_i);
        end
        if (fetch_ack_i !== exp_pkt_i.valid) begin
            report_error("fetch_ack_o", 32'(fetch_ack_i), 32'(exp_pkt_i.valid));
        end
        if (packet_i.valid !== exp_pkt_i.valid) begin
            report_error("packet valid", 32'(packet_i.valid), 32'(exp_pkt_i.valid));
        end else if (exp_pkt_i.valid) begin
            if (packet_i.pc !== exp_pkt_i.pc)
                report_error("packet pc", packet_i.pc, exp_pkt_i.pc);
            if (packet_i.instr !== exp_pkt_i.instr)
                report_error("packet instr", packet_i.instr, exp_pkt_i.instr);
            if (packet_i.compressed !== exp_pkt_i.compressed)
                report_error("packet compressed", 32'(packet_i.compressed),
                             32'(exp_pkt_i.compressed));
            if (packet_i.speculative !== exp_pkt_i.speculative)
                report_error("packet speculative", 32'(packet_i.speculative),
                             32'(exp_pkt_i.speculative));
            if (packet_i.mispredicted !== exp_pkt_i.mispredicted)
                report_error("packet mispredicted", 32'(packet_i.mispredicted),
                             32'(exp_pkt_i.mispredicted));
        end
    endtask

    always @(posedge clk_i) begin
        if (all_done_i) begin
            $display("Summary: %0d tests, %0d checks, %0d errors",
                     tests_done, total_checks, error_count_o);
        end else if (rst_n_i) begin
            compare_outputs();
            if (test_last_i) begin
                $display("test %0d finished: %0d checks, %0d errors",
                         test_num_i, test_checks, test_errors);
                tests_done++;
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule : fe_checker

/* test/tb_front_end.sv */
/*
 * Front end testbench
 * Drives the DUT on falling edges with LFSR stimulus, answers fetches
 * from a memory model, and keeps a reference model of the PC, the
 * predictor tables and the fetch packet for the checker to compare
 */

`timescale 1ns/10ps

module tb_front_end;

    localparam int  PERIOD      = 8;
    localparam int  PRED_SIZE   = 32;
    localparam int  BTB_ENTRIES = 32;
    localparam int  PB          = $clog2(PRED_SIZE);
    localparam int  BB          = $clog2(BTB_ENTRIES);
    localparam int  LEN_SEQ = 24, LEN_TRAP = 6, LEN_RES = 8, LEN_PRED = 8;
    localparam int  LEN_MISP = 5, LEN_STALL = 10, LEN_RAND = 80;
    localparam int  TOTAL_CYCLES = LEN_SEQ + LEN_TRAP + LEN_RES + LEN_PRED
                                 + LEN_MISP + LEN_STALL + LEN_RAND;
    localparam fetch_pkg::data_word_t ADDR_A = 32'h0000_0100;
    localparam fetch_pkg::data_word_t ADDR_T = 32'h0000_0200;

    typedef struct packed {
        logic                  fetch;
        fetch_pkg::data_word_t addr;
        fetch_pkg::fetch_pkt_t pkt;
    } expect_t;

    logic clk, rst_n, stall, flush, branch_flush, fetch_valid;
    fetch_pkg::trap_t      trap;
    fetch_pkg::resolve_t   resolve;
    fetch_pkg::data_word_t fetch_instr;
    logic                  dut_fetch, dut_ack;
    fetch_pkg::data_word_t dut_addr;
    fetch_pkg::fetch_pkt_t dut_pkt;

    // Expected values for the cycle now being driven
    logic                  exp_fetch;
    fetch_pkg::data_word_t exp_addr;
    fetch_pkg::fetch_pkt_t exp_pkt;
    int                    test_num;
    logic                  test_last, all_done;
    int                    error_count;

    // Test number handed to the checker with the first stimulus of each test
    int                    active_test;

    // Reference model state
    fetch_pkg::data_word_t m_pc;
    logic [1:0]            m_cnt [PRED_SIZE];
    logic                  m_btb_valid [BTB_ENTRIES];
    fetch_pkg::data_word_t m_btb_tag [BTB_ENTRIES];
    fetch_pkg::data_word_t m_btb_tgt [BTB_ENTRIES];
    fetch_pkg::fetch_pkt_t m_pkt;
    logic                  m_spec;
    logic                  mem_pending;
    logic [31:0]           lfsr_q;

    front_end #(
        .PREDICTOR_SIZE ( PRED_SIZE   ),
        .BTB_SIZE       ( BTB_ENTRIES )
    ) dut0 (
        .clk_i          ( clk          ),
        .rst_n_i        ( rst_n        ),
        .stall_i        ( stall        ),
        .flush_i        ( flush        ),
        .branch_flush_i ( branch_flush ),
        .trap_i         ( trap         ),
        .resolve_i      ( resolve      ),
        .fetch_valid_i  ( fetch_valid  ),
        .fetch_instr_i  ( fetch_instr  ),
        .fetch_o        ( dut_fetch    ),
        .fetch_addr_o   ( dut_addr     ),
        .fetch_ack_o    ( dut_ack      ),
        .packet_o       ( dut_pkt      )
    );

    fe_checker checker0 (
        .clk_i         ( clk         ),
        .rst_n_i       ( rst_n       ),
        .fetch_i       ( dut_fetch   ),
        .fetch_addr_i  ( dut_addr    ),
        .fetch_ack_i   ( dut_ack     ),
        .packet_i      ( dut_pkt     ),
        .exp_fetch_i   ( exp_fetch   ),
        .exp_addr_i    ( exp_addr    ),
        .exp_pkt_i     ( exp_pkt     ),
        .test_num_i    ( test_num    ),
        .test_last_i   ( test_last   ),
        .all_done_i    ( all_done    ),
        .error_count_o ( error_count )
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Random source
    // ====================

    // Taps 32, 22, 2, 1 give a maximal length sequence
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // ====================
    // Reference model
    // ====================

    task automatic model_reset();
        m_pc = fetch_pkg::PC_RESET_VALUE;
        for (int i = 0; i < PRED_SIZE; i++) begin
            m_cnt[i] = 2'b01;
        end
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_btb_valid[i] = 1'b0;
            m_btb_tag[i]   = '0;
            m_btb_tgt[i]   = '0;
        end
        m_pkt       = '0;
        m_spec      = 1'b0;
        mem_pending = 1'b0;
    endtask

    // Returns this cycle's expected outputs, then advances the model past the edge
    function automatic expect_t model_cycle(input fetch_pkg::trap_t tr,
                                            input fetch_pkg::resolve_t rs,
                                            input logic st, input logic fl, input logic bf,
                                            input logic fv, input fetch_pkg::data_word_t ins);
        int         pidx, bidx, ridx, rbidx;
        logic       hit, comp, outcome, mis, redirect, trap_req;
        logic [1:0] ctr;
        expect_t    e;
        pidx     = int'(m_pc[PB:1]);
        bidx     = int'(m_pc[BB:1]);
        ridx     = int'(rs.instr_addr[PB:1]);
        rbidx    = int'(rs.instr_addr[BB:1]);
        hit      = m_btb_valid[bidx] && (m_btb_tag[bidx] == (m_pc >> (BB + 1)));
        comp     = (ins[1:0] != 2'b11);
        ctr      = m_cnt[ridx];
        outcome  = rs.taken | rs.jump;
        mis      = rs.executed & rs.speculative & (outcome != ctr[1]);
        redirect = rs.speculative ? mis : outcome;
        trap_req = tr.exception | tr.interrupt;
        e.pkt    = m_pkt;
        e.fetch  = trap_req | rs.executed | !st;
        if (trap_req) begin
            e.addr = tr.handler_pc;
        end else if (rs.executed && redirect) begin
            e.addr = rs.next_addr;
        end else if (st) begin
            e.addr = m_pc;
        end else if (hit && m_cnt[pidx][1]) begin
            e.addr = m_btb_tgt[bidx];
        end else begin
            e.addr = m_pc + ((comp && fv) ? 32'd2 : 32'd4);
        end
        // Packet and speculation register advance only without stall
        if (!st) begin
            m_pkt = '{valid: fv, compressed: comp, speculative: m_spec,
                      mispredicted: mis, pc: m_pc, instr: ins};
        end
        if (bf) begin
            m_pkt.valid = 1'b0;
        end
        if (fl) begin
            m_spec = 1'b0;
        end else if (!st) begin
            m_spec = hit;
        end
        if (rs.executed && (rs.branch || rs.jump)) begin
            if (outcome && ctr != 2'b11) begin
                m_cnt[ridx] = ctr + 2'd1;
            end else if (!outcome && ctr != 2'b00) begin
                m_cnt[ridx] = ctr - 2'd1;
            end
            if (outcome) begin
                m_btb_valid[rbidx] = 1'b1;
                m_btb_tag[rbidx]   = rs.instr_addr >> (BB + 1);
                m_btb_tgt[rbidx]   = rs.next_addr;
            end
        end
        m_pc = e.addr;
        return e;
    endfunction

    // ====================
    // Stimulus
    // ====================

    function automatic fetch_pkg::resolve_t make_resolve(input logic br, input logic jp,
            input logic tk, input logic sp, input fetch_pkg::data_word_t ia,
            input fetch_pkg::data_word_t na);
        return '{executed: 1'b1, branch: br, jump: jp, taken: tk, speculative: sp,
                 instr_addr: ia, next_addr: na};
    endfunction

    function automatic fetch_pkg::trap_t make_trap(input fetch_pkg::data_word_t handler);
        return '{exception: 1'b1, interrupt: 1'b0, handler_pc: handler};
    endfunction

    // Memory answers the previous cycle's fetch with a random word
    task automatic run_cycle(input fetch_pkg::trap_t tr, input fetch_pkg::resolve_t rs,
                             input logic st, input logic fl, input logic bf, input logic last);
        expect_t e;
        @(negedge clk);
        rst_n        = 1'b1;
        test_num     = active_test;
        trap         = tr;
        resolve      = rs;
        stall        = st;
        flush        = fl;
        branch_flush = bf;
        fetch_valid  = mem_pending;
        fetch_instr  = rand_bits(32);
        e            = model_cycle(tr, rs, st, fl, bf, fetch_valid, fetch_instr);
        mem_pending  = e.fetch;
        exp_fetch    = e.fetch;
        exp_addr     = e.addr;
        exp_pkt      = e.pkt;
        test_last    = last;
    endtask

    task automatic run_idle(input int n);
        for (int i = 0; i < n; i++) begin
            run_cycle('0, '0, 1'b0, 1'b0, 1'b0, i == n - 1);
        end
    endtask

    task automatic run_random(input int n);
        fetch_pkg::trap_t    tr;
        fetch_pkg::resolve_t rs;
        logic                jp;
        for (int i = 0; i < n; i++) begin
            tr = '0;
            if (rand_bits(4) == 0) begin
                tr = make_trap(rand_bits(11) << 1);
                // Half of the traps arrive as interrupts
                if (rand_bits(1) != 0) begin
                    tr.exception = 1'b0;
                    tr.interrupt = 1'b1;
                end
            end
            jp = (rand_bits(1) != 0);
            rs = (rand_bits(2) == 0)
               ? make_resolve(!jp, jp, rand_bits(1) != 0, rand_bits(1) != 0,
                              rand_bits(6) << 1, rand_bits(11) << 1)
               : '0;
            run_cycle(tr, rs, rand_bits(2) == 0, rand_bits(4) == 0, rand_bits(4) == 0,
                      i == n - 1);
        end
    endtask

    initial begin
        lfsr_q = 32'h6cb2_cead;
        rst_n = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        branch_flush = 1'b0;
        trap = '0;
        resolve = '0;
        fetch_valid = 1'b0;
        fetch_instr = '0;
        test_num = 0;
        active_test = 0;
        test_last = 1'b0;
        all_done = 1'b0;
        exp_fetch = 1'b0;
        exp_addr = '0;
        exp_pkt = '0;
        model_reset();
        repeat (3) @(posedge clk);

        // Sequential fetch from address 0
        active_test = 1;
        run_idle(LEN_SEQ);

        // Trap wins over a stall and a resolution in the same cycle
        active_test = 2;
        run_cycle(make_trap(32'h400),
                  make_resolve(1'b1, 1'b0, 1'b1, 1'b0, 32'h300, 32'h800),
                  1'b1, 1'b0, 1'b0, 1'b0);
        run_cycle('0, '0, 1'b1, 1'b0, 1'b0, 1'b0);
        run_idle(LEN_TRAP - 2);

        // Taken branch, jump, then a not-taken branch
        active_test = 3;
        run_cycle('0, make_resolve(1'b1, 1'b0, 1'b1, 1'b0, 32'h420, 32'h900),
                  1'b0, 1'b0, 1'b0, 1'b0);
        run_cycle('0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
        run_cycle('0, make_resolve(1'b0, 1'b1, 1'b0, 1'b0, 32'h904, 32'ha00),
                  1'b0, 1'b0, 1'b0, 1'b0);
        run_cycle('0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
        run_cycle('0, make_resolve(1'b1, 1'b0, 1'b0, 1'b0, 32'ha04, 32'ha08),
                  1'b0, 1'b0, 1'b0, 1'b0);
        run_idle(LEN_RES - 5);

        // Two taken resolutions train the buffer, then fetch revisits the branch
        active_test = 4;
        run_cycle('0, make_resolve(1'b1, 1'b0, 1'b1, 1'b0, ADDR_A, ADDR_T),
                  1'b0, 1'b0, 1'b0, 1'b0);
        run_cycle('0, make_resolve(1'b1, 1'b0, 1'b1, 1'b0, ADDR_A, ADDR_T),
                  1'b0, 1'b0, 1'b0, 1'b0);
        run_cycle(make_trap(ADDR_A), '0, 1'b0, 1'b0, 1'b0, 1'b0);
        run_idle(LEN_PRED - 3);

        // Counter now says taken, so a speculative not-taken is a misprediction
        active_test = 5;
        run_cycle('0, make_resolve(1'b1, 1'b0, 1'b0, 1'b1, ADDR_A, ADDR_A + 4),
                  1'b0, 1'b0, 1'b0, 1'b0);
        run_idle(LEN_MISP - 1);

        // Stall holds PC and packet, then a branch flush drops the packet
        active_test = 6;
        for (int i = 0; i < 4; i++) begin
            run_cycle('0, '0, 1'b1, 1'b0, 1'b0, 1'b0);
        end
        // Fetch resumes so that the flushed cycle carries a returned instruction
        run_cycle('0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
        run_cycle('0, '0, 1'b0, 1'b1, 1'b1, 1'b0);
        run_idle(LEN_STALL - 6);

        active_test = 7;
        run_random(LEN_RAND);

        @(negedge clk);
        all_done  = 1'b1;
        test_last = 1'b0;
        @(posedge clk);
        #1;
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the test lengths plus reset and a margin
    initial begin
        #((TOTAL_CYCLES + 3 + 40) * PERIOD);
        $display("Timeout: the tests did not finish in the expected number of cycles");
        $display("Test failed");
        $finish;
    end

endmodule : tb_front_end
